/* Makefile */
SRCS := $(shell grep -v '^+' compile.f) source/core_defines.svh

obj_dir/VrvCoreTb: compile.f $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module rvCoreTb -o VrvCoreTb

.PHONY: run check clean

run: obj_dir/VrvCoreTb
	./obj_dir/VrvCoreTb > run.log; cat run.log
	grep -q "STATUS: PASS" run.log

check:
	grep -q "STATUS: PASS" run.log

clean:
	rm -rf obj_dir run.log

/* compile.f */
+incdir+source
source/core_pkg.sv
source/pipeReg.sv
source/fetchStage.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/memStage.sv
source/rvCore.sv
tb/tbClock.sv
tb/rvCoreTb.sv

/* source/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h8000_0000

// number of architectural integer registers
`define REG_COUNT 32

// ebreak as a full instruction word
`define EBREAK_INST 32'h0010_0073

`endif

/* source/core_pkg.sv */
`include "core_defines.svh"

package core_pkg;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

	typedef enum logic [2:0] {
		brNone, brEq, brNe, brLt, brGe, brLtu, brGeu
	} brCondT;

	typedef enum logic [1:0] {wbAlu, wbLoad, wbPcPlus4} wbSelT;

	// encoded like funct3[1:0] of loads and stores
	typedef enum logic [1:0] {memByte, memHalf, memWord} memSizeT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0] inst;
	} ifIdT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0] inst;
		logic [`XLEN-1:0] rs1Val;
		logic [`XLEN-1:0] rs2Val;
		logic [`XLEN-1:0] imm;
		aluOpT aluOp;
		logic srcAPc;   // auipc
		logic srcBImm;
		brCondT brCond;
		logic jal;
		logic jalr;
		logic memRead;
		logic memWrite;
		memSizeT memSize;
		logic memUnsigned;
		wbSelT wbSel;
		logic [4:0] rdAddr;
		logic regWrite;
		logic illegal;
		logic isEbreak;
	} idExT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0] inst;
		logic [`XLEN-1:0] aluResult;
		logic [`XLEN-1:0] storeData;
		logic memRead;
		logic memWrite;
		memSizeT memSize;
		logic memUnsigned;
		wbSelT wbSel;
		logic [4:0] rdAddr;
		logic regWrite;
		logic illegal;
		logic isEbreak;
	} exMemT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0] inst;
		logic [4:0] rdAddr;
		logic regWrite;
		logic [`XLEN-1:0] wbData;
		logic illegal;
		logic isEbreak;
	} memWbT;

	typedef struct packed {
		logic [`XLEN-1:0] pc;
		logic [31:0] inst;
		logic [4:0] rdAddr;
		logic rdWe;
		logic [`XLEN-1:0] rdData;
		logic illegal;
	} retireT;

endpackage

/* source/decodeStage.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module decodeStage import core_pkg::*; (
	input logic inValid,
	input ifIdT in,
	input idExT exEntry,
	input logic exValid,
	input exMemT memEntry,
	input logic memValid,
	output logic [4:0] rs1Addr,
	output logic [4:0] rs2Addr,
	input logic [`XLEN-1:0] rs1Val,
	input logic [`XLEN-1:0] rs2Val,
	output logic stall,
	output idExT out
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [4:0] rd;
	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;
	aluOpT arithOp;
	logic legal;
	logic exHit;
	logic memHit;

	assign opcode = in.inst[6:0];
	assign rd = in.inst[11:7];
	assign funct3 = in.inst[14:12];
	assign rs1Addr = in.inst[19:15];
	assign rs2Addr = in.inst[24:20];
	assign funct7 = in.inst[31:25];

	assign immI = {{20{in.inst[31]}}, in.inst[31:20]};
	assign immS = {{20{in.inst[31]}}, in.inst[31:25], in.inst[11:7]};
	assign immB = {{19{in.inst[31]}}, in.inst[31], in.inst[7], in.inst[30:25],
		in.inst[11:8], 1'b0};
	assign immU = {in.inst[31:12], 12'b0};
	assign immJ = {{11{in.inst[31]}}, in.inst[31], in.inst[19:12], in.inst[20],
		in.inst[30:21], 1'b0};

	// shared by OP and OP-IMM, sub only exists for OP
	always_comb begin
		case (funct3)
			3'b000: arithOp = (opcode[5] && funct7[5]) ? aluSub : aluAdd;
			3'b001: arithOp = aluSll;
			3'b010: arithOp = aluSlt;
			3'b011: arithOp = aluSltu;
			3'b100: arithOp = aluXor;
			3'b101: arithOp = funct7[5] ? aluSra : aluSrl;
			3'b110: arithOp = aluOr;
			default: arithOp = aluAnd;
		endcase
	end

	always_comb begin
		out = '0;
		out.pc = in.pc;
		out.inst = in.inst;
		out.rs1Val = rs1Val;
		out.rs2Val = rs2Val;
		out.rdAddr = rd;
		out.aluOp = aluAdd;
		out.brCond = brNone;
		out.wbSel = wbAlu;
		out.memSize = memWord;
		legal = 1'b1;
		case (opcode)
			7'b0110111: begin // lui
				out.imm = immU;
				out.srcBImm = 1'b1;
				out.aluOp = aluPassB;
				out.regWrite = 1'b1;
			end
			7'b0010111: begin // auipc
				out.imm = immU;
				out.srcAPc = 1'b1;
				out.srcBImm = 1'b1;
				out.regWrite = 1'b1;
			end
			7'b1101111: begin
				out.imm = immJ;
				out.jal = 1'b1;
				out.wbSel = wbPcPlus4;
				out.regWrite = 1'b1;
			end
			7'b1100111: begin
				out.imm = immI;
				out.srcBImm = 1'b1; // target rs1 + imm through the ALU
				out.jalr = 1'b1;
				out.wbSel = wbPcPlus4;
				out.regWrite = 1'b1;
				legal = (funct3 == 3'b000);
			end
			7'b1100011: begin
				out.imm = immB;
				case (funct3)
					3'b000: out.brCond = brEq;
					3'b001: out.brCond = brNe;
					3'b100: out.brCond = brLt;
					3'b101: out.brCond = brGe;
					3'b110: out.brCond = brLtu;
					3'b111: out.brCond = brGeu;
					default: legal = 1'b0;
				endcase
			end
			7'b0000011: begin
				out.imm = immI;
				out.srcBImm = 1'b1;
				out.memRead = 1'b1;
				out.memSize = memSizeT'(funct3[1:0]);
				out.memUnsigned = funct3[2];
				out.wbSel = wbLoad;
				out.regWrite = 1'b1;
				legal = (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
			end
			7'b0100011: begin
				out.imm = immS;
				out.srcBImm = 1'b1;
				out.memWrite = 1'b1;
				out.memSize = memSizeT'(funct3[1:0]);
				legal = (funct3 inside {3'b000, 3'b001, 3'b010});
			end
			7'b0010011: begin
				out.imm = immI;
				out.srcBImm = 1'b1;
				out.aluOp = arithOp;
				out.regWrite = 1'b1;
				if (funct3 == 3'b001) begin
					legal = (funct7 == 7'b0000000);
				end else if (funct3 == 3'b101) begin
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
				end
			end
			7'b0110011: begin
				out.aluOp = arithOp;
				out.regWrite = 1'b1;
				legal = (funct7 == 7'b0000000) ||
					(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
			end
			7'b1110011: begin
				legal = (in.inst == `EBREAK_INST);
				out.isEbreak = legal;
			end
			default: legal = 1'b0;
		endcase
		// illegal retires with no side effects
		if (!legal) begin
			out.regWrite = 1'b0;
			out.memRead = 1'b0;
			out.memWrite = 1'b0;
			out.jal = 1'b0;
			out.jalr = 1'b0;
			out.brCond = brNone;
		end
		if (rd == 5'd0) begin
			out.regWrite = 1'b0;
		end
		out.illegal = !legal;
	end

	// RAW against the two older stages, writeback is covered by the register file
	assign exHit = exValid && exEntry.regWrite &&
		((rs1Addr != 5'd0 && exEntry.rdAddr == rs1Addr) ||
		(rs2Addr != 5'd0 && exEntry.rdAddr == rs2Addr));
	assign memHit = memValid && memEntry.regWrite &&
		((rs1Addr != 5'd0 && memEntry.rdAddr == rs1Addr) ||
		(rs2Addr != 5'd0 && memEntry.rdAddr == rs2Addr));
	assign stall = inValid && (exHit || memHit);

endmodule

/* source/executeStage.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module executeStage import core_pkg::*; (
	input logic inValid,
	input idExT in,
	output logic redirect,
	output logic [`XLEN-1:0] redirectPc,
	output exMemT out
);

	logic [`XLEN-1:0] opA;
	logic [`XLEN-1:0] opB;
	logic [`XLEN-1:0] aluResult;
	logic taken;

	assign opA = in.srcAPc ? in.pc : in.rs1Val;
	assign opB = in.srcBImm ? in.imm : in.rs2Val;

	always_comb begin
		case (in.aluOp)
			aluAdd: aluResult = opA + opB;
			aluSub: aluResult = opA - opB;
			aluSll: aluResult = opA << opB[4:0];
			aluSlt: aluResult = `XLEN'($signed(opA) < $signed(opB));
			aluSltu: aluResult = `XLEN'(opA < opB);
			aluXor: aluResult = opA ^ opB;
			aluSrl: aluResult = opA >> opB[4:0];
			aluSra: aluResult = $unsigned($signed(opA) >>> opB[4:0]);
			aluOr: aluResult = opA | opB;
			aluAnd: aluResult = opA & opB;
			default: aluResult = opB; // lui
		endcase
	end

	// compare always on the register values
	always_comb begin
		case (in.brCond)
			brEq: taken = (in.rs1Val == in.rs2Val);
			brNe: taken = (in.rs1Val != in.rs2Val);
			brLt: taken = ($signed(in.rs1Val) < $signed(in.rs2Val));
			brGe: taken = ($signed(in.rs1Val) >= $signed(in.rs2Val));
			brLtu: taken = (in.rs1Val < in.rs2Val);
			brGeu: taken = (in.rs1Val >= in.rs2Val);
			default: taken = 1'b0;
		endcase
	end

	assign redirect = inValid && (in.jal || in.jalr || taken);
	assign redirectPc = in.jalr ? {aluResult[`XLEN-1:1], 1'b0} : in.pc + in.imm;

	always_comb begin
		out.pc = in.pc;
		out.inst = in.inst;
		out.aluResult = aluResult;
		out.storeData = in.rs2Val;
		out.memRead = in.memRead;
		out.memWrite = in.memWrite;
		out.memSize = in.memSize;
		out.memUnsigned = in.memUnsigned;
		out.wbSel = in.wbSel;   // pcPlus4 for jal and jalr
		out.rdAddr = in.rdAddr;
		out.regWrite = in.regWrite;
		out.illegal = in.illegal;
		out.isEbreak = in.isEbreak;
	end

endmodule

/* source/fetchStage.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module fetchStage import core_pkg::*; (
	input logic clk,
	input logic arstN,
	input logic stall,
	input logic redirect,
	input logic halted,
	input logic [`XLEN-1:0] redirectPc,
	output logic [`XLEN-1:0] imemAddr,
	input logic [31:0] imemData,
	output logic outValid,
	output ifIdT out
);

	logic [`XLEN-1:0] pc;  // address of the word now on imemData
	logic reqValid;

	// next request, the memory answers one cycle later
	always_comb begin
		if (redirect) begin
			imemAddr = redirectPc;
		end else if (stall || halted) begin
			imemAddr = pc;     // re-read the word decode could not take
		end else begin
			imemAddr = pc + `XLEN'd4;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pc <= `RESET_PC - `XLEN'd4; // so the first request is RESET_PC
			reqValid <= 1'b0;
		end else begin
			pc <= imemAddr;
			reqValid <= !halted;
		end
	end

	// word fetched on the old path is dropped
	assign outValid = reqValid && !redirect && !halted;
	assign out.pc = pc;
	assign out.inst = imemData;

	// redirect targets come from execute
	fetchAligned: assert property (@(posedge clk) disable iff (!arstN)
		imemAddr[1:0] == 2'b00);

endmodule

/* source/memStage.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module memStage import core_pkg::*; (
	input logic inValid,
	input exMemT in,
	output logic [`XLEN-1:0] dmemAddr,
	output logic [`XLEN-1:0] dmemWdata,
	output logic [3:0] dmemWmask,
	output logic dmemWe,
	output logic dmemRe,
	input logic [`XLEN-1:0] dmemRdata,
	output memWbT out
);

	logic [1:0] offset;
	logic [`XLEN-1:0] laneData;
	logic [`XLEN-1:0] loadVal;

	assign dmemAddr = in.aluResult;
	assign offset = in.aluResult[1:0];
	assign dmemWe = inValid && in.memWrite;   // one strobe per store
	assign dmemRe = inValid && in.memRead;

	// replicate the data so every lane carries it, the mask picks one
	always_comb begin
		case (in.memSize)
			memByte: begin
				dmemWdata = {4{in.storeData[7:0]}};
				dmemWmask = 4'b0001 << offset;
			end
			memHalf: begin
				dmemWdata = {2{in.storeData[15:0]}};
				dmemWmask = 4'b0011 << offset;
			end
			default: begin
				dmemWdata = in.storeData;
				dmemWmask = 4'b1111;
			end
		endcase
	end

	always_comb begin
		laneData = dmemRdata >> {offset, 3'b000};
		case (in.memSize)
			memByte: loadVal = in.memUnsigned ? {{(`XLEN-8){1'b0}}, laneData[7:0]} :
				{{(`XLEN-8){laneData[7]}}, laneData[7:0]};
			memHalf: loadVal = in.memUnsigned ? {{(`XLEN-16){1'b0}}, laneData[15:0]} :
				{{(`XLEN-16){laneData[15]}}, laneData[15:0]};
			default: loadVal = dmemRdata;
		endcase
	end

	always_comb begin
		out.pc = in.pc;
		out.inst = in.inst;
		out.rdAddr = in.rdAddr;
		out.regWrite = in.regWrite;
		out.illegal = in.illegal;
		out.isEbreak = in.isEbreak;
		case (in.wbSel)
			wbLoad: out.wbData = loadVal;
			wbPcPlus4: out.wbData = in.pc + `XLEN'd4;
			default: out.wbData = in.aluResult;
		endcase
	end

	// address comes from a register plus offset in execute
	always_comb begin
		if (inValid && (in.memRead || in.memWrite)) begin
			if (in.memSize == memHalf) begin
				assert (offset[0] == 1'b0) else $error("misaligned halfword at %h", dmemAddr);
			end else if (in.memSize == memWord) begin
				assert (offset == 2'b00) else $error("misaligned word at %h", dmemAddr);
			end
		end
	end

endmodule

/* source/pipeReg.sv */
`timescale 1ns/10ps

module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic arstN,
	input logic stall,
	input logic flush,
	input logic inValid,
	input payloadT inData,
	output logic outValid,
	output payloadT outData
);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			outValid <= 1'b0;
		end else if (flush) begin
			outValid <= 1'b0; // squashed entry becomes a bubble
		end else if (!stall) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			outData <= inData;
		end
	end

	// only a real entry is ever held
	stallHoldsValid: assert property (@(posedge clk) disable iff (!arstN)
		stall |-> outValid);

endmodule

/* source/regFile.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module regFile (
	input logic clk,
	input logic arstN,
	input logic [4:0] rs1Addr,
	input logic [4:0] rs2Addr,
	input logic [4:0] rdAddr,
	input logic we,
	input logic [`XLEN-1:0] rdData,
	output logic [`XLEN-1:0] rs1Val,
	output logic [`XLEN-1:0] rs2Val
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (we && rdAddr != 5'd0) begin
			regs[rdAddr] <= rdData;
		end
	end

	function automatic logic [`XLEN-1:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0) begin
			return '0;
		end
		if (we && addr == rdAddr) begin
			return rdData; // writeback in the same cycle
		end
		return regs[addr];
	endfunction

	always_comb begin
		rs1Val = readPort(rs1Addr);
		rs2Val = readPort(rs2Addr);
	end

endmodule

/* source/rvCore.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module rvCore import core_pkg::*; (
	input logic clk,
	input logic arstN,
	output logic [`XLEN-1:0] imemAddr,
	input logic [31:0] imemData,
	output logic [`XLEN-1:0] dmemAddr,
	output logic [`XLEN-1:0] dmemWdata,
	output logic [3:0] dmemWmask,
	output logic dmemWe,
	output logic dmemRe,
	input logic [`XLEN-1:0] dmemRdata,
	output logic retireValid,
	output retireT retire,
	output logic halted
);

	logic fetchValid;
	ifIdT fetchOut;
	logic ifIdValid;
	ifIdT ifId;
	logic decStall;
	idExT decOut;
	logic [4:0] rs1Addr;
	logic [4:0] rs2Addr;
	logic [`XLEN-1:0] rs1Val;
	logic [`XLEN-1:0] rs2Val;
	logic idExValid;
	idExT idEx;
	logic redirect;
	logic [`XLEN-1:0] redirectPc;
	exMemT exOut;
	logic exMemValid;
	exMemT exMem;
	logic memInValid;
	memWbT memOut;
	logic memWbValid;
	memWbT memWb;
	logic haltNow;

	fetchStage i_fetch (
		.clk(clk), .arstN(arstN),
		.stall(decStall), .redirect(redirect), .halted(halted), .redirectPc(redirectPc),
		.imemAddr(imemAddr), .imemData(imemData),
		.outValid(fetchValid), .out(fetchOut)
	);

	pipeReg #(.payloadT(ifIdT)) i_ifIdReg (
		.clk(clk), .arstN(arstN), .stall(decStall), .flush(redirect),
		.inValid(fetchValid), .inData(fetchOut), .outValid(ifIdValid), .outData(ifId)
	);

	decodeStage i_decode (
		.inValid(ifIdValid), .in(ifId),
		.exEntry(idEx), .exValid(idExValid), .memEntry(exMem), .memValid(exMemValid),
		.rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rs1Val(rs1Val), .rs2Val(rs2Val),
		.stall(decStall), .out(decOut)
	);

	regFile i_regFile (
		.clk(clk), .arstN(arstN), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr),
		.rdAddr(memWb.rdAddr), .we(memWbValid && memWb.regWrite), .rdData(memWb.wbData),
		.rs1Val(rs1Val), .rs2Val(rs2Val)
	);

	// stalled decode sends a bubble into execute
	pipeReg #(.payloadT(idExT)) i_idExReg (
		.clk(clk), .arstN(arstN), .stall(1'b0), .flush(redirect),
		.inValid(ifIdValid && !decStall), .inData(decOut),
		.outValid(idExValid), .outData(idEx)
	);

	executeStage i_execute (
		.inValid(idExValid), .in(idEx),
		.redirect(redirect), .redirectPc(redirectPc), .out(exOut)
	);

	pipeReg #(.payloadT(exMemT)) i_exMemReg (
		.clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0),
		.inValid(idExValid), .inData(exOut), .outValid(exMemValid), .outData(exMem)
	);

	// nothing younger than a retiring ebreak touches memory or retires
	assign haltNow = halted || (memWbValid && memWb.isEbreak);
	assign memInValid = exMemValid && !haltNow;

	memStage i_mem (
		.inValid(memInValid), .in(exMem),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWmask(dmemWmask),
		.dmemWe(dmemWe), .dmemRe(dmemRe), .dmemRdata(dmemRdata), .out(memOut)
	);

	pipeReg #(.payloadT(memWbT)) i_memWbReg (
		.clk(clk), .arstN(arstN), .stall(1'b0), .flush(1'b0),
		.inValid(memInValid), .inData(memOut), .outValid(memWbValid), .outData(memWb)
	);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			halted <= 1'b0;
		end else if (memWbValid && memWb.isEbreak) begin
			halted <= 1'b1;   // sticky until reset
		end
	end

	assign retireValid = memWbValid;
	assign retire.pc = memWb.pc;
	assign retire.inst = memWb.inst;
	assign retire.rdAddr = memWb.rdAddr;
	assign retire.rdWe = memWb.regWrite;
	assign retire.rdData = memWb.regWrite ? memWb.wbData : '0;
	assign retire.illegal = memWb.illegal;

endmodule

/* tb/rvCoreTb.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module rvCoreTb import core_pkg::*;;

	localparam logic [31:0] DATA_BASE = 32'h0000_2000;

	logic clk;
	logic arstN;
	logic restart;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	logic [31:0] dmemAddr;
	logic [31:0] dmemWdata;
	logic [3:0] dmemWmask;
	logic dmemWe;
	logic dmemRe;
	logic [31:0] dmemRdata;
	logic retireValid;
	retireT retire;
	logic halted;

	logic [31:0] prog [256];
	logic [31:0] dmem [256];
	logic [31:0] sMem [256];   // shadow data memory
	logic [31:0] sRegs [32];
	logic [31:0] sPc;
	logic refHalted;
	logic [31:0] pendAddr;
	logic [31:0] pendOff;
	retireT exp;
	int progLen;
	int seed;
	string testName;
	int testErrors;
	int retired;
	int expLoads;
	int seenLoads;
	int passCount;
	int failCount;
	logic active;
	int cycles;
	int limit;

	tbClock i_clock (.restart(restart), .clk(clk), .arstN(arstN));

	rvCore i_dut (
		.clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWdata(dmemWdata), .dmemWmask(dmemWmask),
		.dmemWe(dmemWe), .dmemRe(dmemRe), .dmemRdata(dmemRdata),
		.retireValid(retireValid), .retire(retire), .halted(halted)
	);

	assign dmemRdata = dmem[dmemAddr[9:2]];   // combinational read

	// registered read of the address fetch sent one cycle ago
	always @(negedge clk) begin
		pendOff = pendAddr - `RESET_PC;
		imemData = (pendOff < 32'd1024) ? prog[pendOff[9:2]] : 32'h0;
		pendAddr = imemAddr;
	end

	always @(negedge clk) begin
		if (active && dmemRe) begin
			seenLoads++;
		end
		if (dmemWe) begin
			for (int b = 0; b < 4; b++) begin
				if (dmemWmask[b]) begin
					dmem[dmemAddr[9:2]][8*b +: 8] = dmemWdata[8*b +: 8];
				end
			end
		end
	end

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic logic [31:0] encR(input logic [31:0] f7, rs2, rs1, f3, rd, op);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encI(input logic [31:0] imm, rs1, f3, rd, op);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encS(input logic [31:0] imm, rs2, rs1, f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] encB(input logic [31:0] imm, rs2, rs1, f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] encU(input logic [31:0] imm20, rd, op);
		return {imm20[19:0], rd[4:0], op[6:0]};
	endfunction

	function automatic logic [31:0] encJ(input logic [31:0] imm, rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
	endfunction

	function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic [31:0] x, y,
		input logic alt);
		case (f3)
			3'd0: return alt ? x - y : x + y;
			3'd1: return x << y[4:0];
			3'd2: return {31'b0, $signed(x) < $signed(y)};
			3'd3: return {31'b0, x < y};
			3'd4: return x ^ y;
			3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'd6: return x | y;
			default: return x & y;
		endcase
	endfunction

	// one instruction on the shadow state by RV32I rules
	function automatic retireT isaStep();
		retireT r;
		logic [31:0] inst, a, b, res, addr, lane, nextPc;
		logic [31:0] immI, immS, immB, immJ;
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		logic [4:0] rd;
		logic legal, wr, take;
		inst = (sPc - `RESET_PC < 32'd1024) ? prog[sPc[9:2]] : 32'h0;
		op = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		rd = inst[11:7];
		a = sRegs[inst[19:15]];
		b = sRegs[inst[24:20]];
		immI = {{20{inst[31]}}, inst[31:20]};
		immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
		immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
		nextPc = sPc + 32'd4;
		legal = 1'b1;
		wr = 1'b0;
		res = 32'h0;
		take = 1'b0;
		case (op)
			7'h37: begin
				res = {inst[31:12], 12'b0};
				wr = 1'b1;
			end
			7'h17: begin
				res = sPc + {inst[31:12], 12'b0};
				wr = 1'b1;
			end
			7'h6f: begin
				res = sPc + 32'd4;
				wr = 1'b1;
				nextPc = sPc + immJ;
			end
			7'h67: begin
				legal = (f3 == 3'd0);
				res = sPc + 32'd4;
				wr = 1'b1;
				nextPc = (a + immI) & ~32'd1;
			end
			7'h63: begin
				case (f3)
					3'd0: take = (a == b);
					3'd1: take = (a != b);
					3'd4: take = $signed(a) < $signed(b);
					3'd5: take = $signed(a) >= $signed(b);
					3'd6: take = a < b;
					3'd7: take = a >= b;
					default: legal = 1'b0;
				endcase
				if (take) nextPc = sPc + immB;
			end
			7'h03: begin
				addr = a + immI;
				lane = sMem[addr[9:2]] >> {addr[1:0], 3'b000};
				wr = 1'b1;
				case (f3)
					3'd0: res = {{24{lane[7]}}, lane[7:0]};
					3'd1: res = {{16{lane[15]}}, lane[15:0]};
					3'd2: res = lane;
					3'd4: res = {24'b0, lane[7:0]};
					3'd5: res = {16'b0, lane[15:0]};
					default: legal = 1'b0;
				endcase
				if (legal) expLoads++;
			end
			7'h23: begin
				addr = a + immS;
				legal = (f3 <= 3'd2);
				if (f3 == 3'd0) sMem[addr[9:2]][{addr[1:0], 3'b000} +: 8] = b[7:0];
				if (f3 == 3'd1) sMem[addr[9:2]][{addr[1], 4'b0000} +: 16] = b[15:0];
				if (f3 == 3'd2) sMem[addr[9:2]] = b;
			end
			7'h13: begin
				if (f3 == 3'd1) legal = (f7 == 7'h00);
				if (f3 == 3'd5) legal = (f7 == 7'h00) || (f7 == 7'h20);
				res = aluRef(f3, a, immI, f3 == 3'd5 && f7[5]);
				wr = 1'b1;
			end
			7'h33: begin
				legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				res = aluRef(f3, a, b, f7[5]);
				wr = 1'b1;
			end
			7'h73: begin
				legal = (inst == `EBREAK_INST);
				refHalted = legal;
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			wr = 1'b0;
			nextPc = sPc + 32'd4;
		end
		if (rd == 5'd0) wr = 1'b0;
		if (wr) sRegs[rd] = res;
		r = '0;
		r.pc = sPc;
		r.inst = inst;
		r.rdAddr = rd;
		r.rdWe = wr;
		r.rdData = wr ? res : 32'h0;
		r.illegal = !legal;
		sPc = nextPc;
		return r;
	endfunction

	task automatic checkField(input string field, input logic [31:0] expV, actV);
		if (expV !== actV) begin
			$display("CHECK FAILED %s %s at pc %h expected %h actual %h",
				testName, field, exp.pc, expV, actV);
			testErrors++;
		end
	endtask

	// retire comparator
	always @(negedge clk) begin
		if (active && retireValid) begin
			retired++;
			if (refHalted) begin
				$display("%s: an instruction retired after ebreak, pc %h", testName, retire.pc);
				testErrors++;
			end else begin
				exp = isaStep();
				checkField("pc", exp.pc, retire.pc);
				checkField("inst", exp.inst, retire.inst);
				checkField("rdAddr", 32'(exp.rdAddr), 32'(retire.rdAddr));
				checkField("rdWe", 32'(exp.rdWe), 32'(retire.rdWe));
				checkField("rdData", exp.rdData, retire.rdData);
				checkField("illegal", 32'(exp.illegal), 32'(retire.illegal));
			end
		end
	end

	always @(negedge clk) begin
		if (active) begin
			cycles++;
			if (cycles > limit) begin
				$display("test %s stalled: no halt within %0d cycles", testName, limit);
				$display("STATUS: FAIL");
				$finish;
			end
		end
	end

	task automatic emit(input logic [31:0] inst);
		prog[progLen] = inst;
		progLen++;
	endtask

	task automatic startProgram();
		for (int i = 0; i < 256; i++) prog[i] = 32'h0;
		progLen = 0;
		emit(encU(32'h2, 1, 7'h37));   // x1 holds the data base
	endtask

	task automatic emitAluRandom();
		int k, f3, rd;
		logic [31:0] imm;
		k = randBelow(4);
		f3 = randBelow(8);
		rd = 2 + randBelow(30);
		if (k == 0) begin
			emit(encR(((f3 == 0 || f3 == 5) && randBelow(2) == 1) ? 7'h20 : 7'h00,
				randBelow(32), randBelow(32), f3, rd, 7'h33));
		end else if (k == 1) begin
			imm = randBelow(4096);
			if (f3 == 1) imm = randBelow(32);
			if (f3 == 5) imm = (randBelow(2) == 1 ? 32'h400 : 32'h0) | randBelow(32);
			emit(encI(imm, randBelow(32), f3, rd, 7'h13));
		end else begin
			emit(encU(randBelow(1 << 20), rd, k == 2 ? 7'h37 : 7'h17));
		end
	endtask

	task automatic runTest(input string name);
		emit(`EBREAK_INST);
		testName = name;
		testErrors = 0;
		retired = 0;
		expLoads = 0;
		seenLoads = 0;
		@(negedge clk);
		restart = 1'b1;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fillWord(DATA_BASE + 32'(i) * 4);
			sMem[i] = dmem[i];
		end
		for (int i = 0; i < 32; i++) sRegs[i] = 32'h0;
		sPc = `RESET_PC;
		refHalted = 1'b0;
		@(posedge arstN);
		restart = 1'b0;
		cycles = 0;
		limit = 20 * progLen + 100;
		active = 1'b1;
		while (!halted) @(negedge clk);
		repeat (5) @(negedge clk);
		active = 1'b0;
		if (!refHalted) begin
			$display("%s: core halted before the reference reached ebreak", name);
			testErrors++;
		end
		if (seenLoads != expLoads) begin
			$display("CHECK FAILED %s dmemRe strobes expected %0d actual %0d", name,
				expLoads, seenLoads);
			testErrors++;
		end
		for (int i = 0; i < 256; i++) begin
			if (dmem[i] !== sMem[i]) begin
				$display("CHECK FAILED %s mem %h expected %h actual %h", name,
					DATA_BASE + 32'(i) * 4, sMem[i], dmem[i]);
				testErrors++;
			end
		end
		$display("test %s: %s, %0d retired, %0d errors", name,
			testErrors == 0 ? "ok" : "failed", retired, testErrors);
		if (testErrors == 0) passCount++;
		else failCount++;
	endtask

	initial begin
		int f3, off, size;
		int loadF3 [5] = '{0, 1, 2, 4, 5};
		int brF3 [6] = '{0, 1, 4, 5, 6, 7};
		seed = 32'h83e7;
		restart = 1'b0;
		imemData = 32'h0;
		pendAddr = `RESET_PC;
		active = 1'b0;
		passCount = 0;
		failCount = 0;

		startProgram();
		repeat (40) emitAluRandom();
		runTest("aluRandom");

		startProgram();
		for (int r = 2; r < 10; r++) begin
			emit(encU(randBelow(1 << 20), r, 7'h37));
			emit(encI(randBelow(4096), r, 0, r, 7'h13));
		end
		repeat (16) begin
			size = randBelow(3);
			off = randBelow(16) * 4;
			if (size == 0) off += randBelow(4);
			if (size == 1) off += 2 * randBelow(2);
			emit(encS(off, 2 + randBelow(8), 1, size));
		end
		repeat (16) begin
			f3 = loadF3[randBelow(5)];
			off = randBelow(16) * 4;
			if (f3 == 0 || f3 == 4) off += randBelow(4);
			if (f3 == 1 || f3 == 5) off += 2 * randBelow(2);
			emit(encI(off, 1, f3, 10 + randBelow(22), 7'h03));
		end
		runTest("loadStore");

		startProgram();
		for (int i = 0; i < 12; i++) begin
			emit(encI(randBelow(5) - 2, 0, 0, 2, 7'h13));
			emit(encI(randBelow(5) - 2, 0, 0, 3, 7'h13));
			emit(encB(randBelow(2) == 1 ? 12 : 8, 3, 2, brF3[i % 6]));
			emit(encI(randBelow(100), 4, 0, 4, 7'h13));
			emit(encI(randBelow(100), 5, 0, 6, 7'h13));
			emit(encJ(8, 7 + randBelow(4)));
			emit(encI(1, 0, 0, 11, 7'h13));   // skipped by the jal
			emit(encU(0, 12, 7'h17));
			emit(encI(12, 12, 0, 13 + randBelow(4), 7'h67));
			emit(encI(1, 0, 0, 17, 7'h13));   // skipped by the jalr
		end
		runTest("controlFlow");

		startProgram();
		repeat (8) begin
			off = randBelow(16) * 4;
			emit(encI(randBelow(4096), 2, 0, 2, 7'h13));
			emit(encR(0, 2, 2, 0, 3, 7'h33));
			emit(encR(7'h20, 2, 3, 0, 4, 7'h33));
			emit(encS(off, 4, 1, 2));
			emit(encI(off, 1, 2, 5, 7'h03));
			emit(encR(0, 4, 5, 0, 6, 7'h33));
		end
		runTest("dependChains");

		startProgram();
		for (int i = 0; i < 5; i++) begin
			repeat (3) emitAluRandom();
			case (i)
				0: emit(32'hffff_ffff);
				1: emit(32'h0000_0000);
				2: emit(encI(0, 2, 3, 7, 7'h03));   // ld is not RV32I
				3: emit(encS(0, 3, 1, 3));
				default: emit(encR(7'h01, 3, 2, 0, 8, 7'h33));   // mul
			endcase
			emit(encS(4 * i, 2 + randBelow(30), 1, 2));
		end
		runTest("illegalInst");

		startProgram();
		repeat (6) emitAluRandom();
		emit(`EBREAK_INST);
		repeat (4) emitAluRandom();   // must never retire
		emit(encS(0, 2, 1, 2));
		runTest("haltOnEbreak");

		$display("tests passed %0d failed %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* tb/tbClock.sv */
`timescale 1ns/10ps

module tbClock (
	input logic restart,
	output logic clk,
	output logic arstN
);

	always #20 clk = ~clk;

	// reset at start and again on every restart request
	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		repeat (2) @(negedge clk);
		arstN = 1'b1;
		forever begin
			@(posedge restart);
			arstN = 1'b0;
			repeat (2) @(negedge clk);
			arstN = 1'b1;
		end
	end

endmodule
